/* files.f */
+incdir+testbench
src/crypto_pkg.sv
src/addr_counters.sv
src/sponge_duplex.sv
src/crypto_fsm.sv
src/crypto_control.sv
testbench/crypto_control_asserts.sv
testbench/crypto_control_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the crypto controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module crypto_control_tb -f files.f -o crypto_control_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/crypto_control_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* src/addr_counters.sv */
`timescale 1ns/10ps

module addr_counters (
    input  logic              clk,
    input  logic              ctr_load,
    input  crypto_pkg::word_t ctr_base,
    input  crypto_pkg::word_t ctr_limit,
    input  logic              ctr_inc,
    input  logic              out_load,
    input  crypto_pkg::word_t out_base,
    input  logic              out_inc,
    input  logic              sel_out,

    output crypto_pkg::word_t mab,
    output logic              range_done
);

    crypto_pkg::word_t ctr;
    crypto_pkg::word_t limit_q;
    crypto_pkg::word_t out_ctr;

    // input range walker
    always_ff @(posedge clk)
    begin
        if (ctr_load)
            ctr <= ctr_base;
        else if (ctr_inc)
            ctr <= ctr + crypto_pkg::word_t'(crypto_pkg::WORD_BYTES);
    end

    always_ff @(posedge clk)
    begin
        if (ctr_load)
            limit_q <= ctr_limit;
    end

    // output pointer for the body result
    always_ff @(posedge clk)
    begin
        if (out_load)
            out_ctr <= out_base;
        else if (out_inc)
            out_ctr <= out_ctr + crypto_pkg::word_t'(crypto_pkg::WORD_BYTES);
    end

    // limit is exclusive
    assign range_done = (ctr >= limit_q);

    assign mab = sel_out ? out_ctr : ctr;

endmodule

/* src/crypto_control.sv */
`timescale 1ns/10ps

module crypto_control (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  logic              cmd_wrap,
    input  logic              cmd_unwrap,
    input  logic              cmd_id,
    input  logic              cmd_id_prev,
    input  crypto_pkg::word_t mem_in,
    input  crypto_pkg::word_t pc,
    input  crypto_pkg::word_t r10,
    input  crypto_pkg::word_t r11,
    input  crypto_pkg::word_t r12,
    input  crypto_pkg::word_t r13,
    input  crypto_pkg::word_t r14,
    input  crypto_pkg::word_t r15,
    input  crypto_pkg::word_t sm_data,
    input  crypto_pkg::key_t  sm_key,
    input  crypto_pkg::word_t sm_prev_id,
    input  logic              sm_data_select_valid,
    input  logic              sm_key_select_valid,

    output logic              busy,
    output crypto_pkg::word_t sm_data_select,
    output crypto_pkg::word_t sm_key_select,
    output logic              mb_en,
    output logic [1:0]        mb_wr,
    output crypto_pkg::word_t mab,
    output logic              reg_write,
    output crypto_pkg::word_t data_out
);

    logic                   ctr_load;
    crypto_pkg::word_t      ctr_base;
    crypto_pkg::word_t      ctr_limit;
    logic                   ctr_inc;
    logic                   out_load;
    crypto_pkg::word_t      out_base;
    logic                   out_inc;
    logic                   sel_out;
    logic                   range_done;

    logic                   duplex_init;
    logic                   duplex_step;
    crypto_pkg::duplex_op_t duplex_op;
    crypto_pkg::word_t      duplex_in;
    logic                   duplex_busy;
    crypto_pkg::word_t      duplex_out;
    logic                   duplex_ready;

    // module lookup by address in r15, key lookup by the caller's pc
    assign sm_data_select = r15;
    assign sm_key_select  = pc;

    crypto_fsm i_crypto_fsm (
        .clk                  (clk),
        .reset                (reset),
        .start                (start),
        .cmd_wrap             (cmd_wrap),
        .cmd_unwrap           (cmd_unwrap),
        .cmd_id               (cmd_id),
        .cmd_id_prev          (cmd_id_prev),
        .mem_in               (mem_in),
        .r10                  (r10),
        .r11                  (r11),
        .r12                  (r12),
        .r13                  (r13),
        .r14                  (r14),
        .r15                  (r15),
        .sm_data              (sm_data),
        .sm_prev_id           (sm_prev_id),
        .sm_data_select_valid (sm_data_select_valid),
        .sm_key_select_valid  (sm_key_select_valid),
        .range_done           (range_done),
        .duplex_busy          (duplex_busy),
        .duplex_out           (duplex_out),
        .duplex_ready         (duplex_ready),
        .busy                 (busy),
        .mb_en                (mb_en),
        .mb_wr                (mb_wr),
        .reg_write            (reg_write),
        .data_out             (data_out),
        .ctr_load             (ctr_load),
        .ctr_base             (ctr_base),
        .ctr_limit            (ctr_limit),
        .ctr_inc              (ctr_inc),
        .out_load             (out_load),
        .out_base             (out_base),
        .out_inc              (out_inc),
        .sel_out              (sel_out),
        .duplex_init          (duplex_init),
        .duplex_step          (duplex_step),
        .duplex_op            (duplex_op),
        .duplex_in            (duplex_in)
    );

    addr_counters i_addr_counters (
        .clk        (clk),
        .ctr_load   (ctr_load),
        .ctr_base   (ctr_base),
        .ctr_limit  (ctr_limit),
        .ctr_inc    (ctr_inc),
        .out_load   (out_load),
        .out_base   (out_base),
        .out_inc    (out_inc),
        .sel_out    (sel_out),
        .mab        (mab),
        .range_done (range_done)
    );

    sponge_duplex i_sponge_duplex (
        .clk            (clk),
        .reset          (reset),
        .init           (duplex_init),
        .step           (duplex_step),
        .op             (duplex_op),
        .data_in        (duplex_in),
        .key            (sm_key),
        .busy           (duplex_busy),
        .data_out       (duplex_out),
        .data_out_ready (duplex_ready)
    );

endmodule

/* src/crypto_fsm.sv */
`timescale 1ns/10ps

module crypto_fsm (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  logic                   cmd_wrap,
    input  logic                   cmd_unwrap,
    input  logic                   cmd_id,
    input  logic                   cmd_id_prev,
    input  crypto_pkg::word_t      mem_in,
    input  crypto_pkg::word_t      r10,
    input  crypto_pkg::word_t      r11,
    input  crypto_pkg::word_t      r12,
    input  crypto_pkg::word_t      r13,
    input  crypto_pkg::word_t      r14,
    input  crypto_pkg::word_t      r15,
    input  crypto_pkg::word_t      sm_data,
    input  crypto_pkg::word_t      sm_prev_id,
    input  logic                   sm_data_select_valid,
    input  logic                   sm_key_select_valid,
    input  logic                   range_done,
    input  logic                   duplex_busy,
    input  crypto_pkg::word_t      duplex_out,
    input  logic                   duplex_ready,

    output logic                   busy,
    output logic                   mb_en,
    output logic [1:0]             mb_wr,
    output logic                   reg_write,
    output crypto_pkg::word_t      data_out,
    output logic                   ctr_load,
    output crypto_pkg::word_t      ctr_base,
    output crypto_pkg::word_t      ctr_limit,
    output logic                   ctr_inc,
    output logic                   out_load,
    output crypto_pkg::word_t      out_base,
    output logic                   out_inc,
    output logic                   sel_out,
    output logic                   duplex_init,
    output logic                   duplex_step,
    output crypto_pkg::duplex_op_t duplex_op,
    output crypto_pkg::word_t      duplex_in
);

    crypto_pkg::ctrl_state_t state;
    crypto_pkg::ctrl_state_t next_state;
    crypto_pkg::word_t       din_q;

    logic sm_valid;
    logic do_wrap;
    logic tag_match;

    // id looks the module up by address, the others by key
    assign sm_valid  = cmd_id ? sm_data_select_valid : sm_key_select_valid;
    assign do_wrap   = cmd_wrap | cmd_unwrap;
    assign tag_match = duplex_ready && (duplex_out == mem_in);

    always_comb
    begin
        next_state = state;
        case (state)
            crypto_pkg::ST_IDLE:
                if (start)
                    next_state = crypto_pkg::ST_CHECK;
            crypto_pkg::ST_CHECK:
                if (!sm_valid)
                    next_state = crypto_pkg::ST_FAIL;
                else if (do_wrap)
                    next_state = crypto_pkg::ST_AD_INIT;
                else
                    next_state = crypto_pkg::ST_DONE;
            crypto_pkg::ST_AD_INIT:
                next_state = crypto_pkg::ST_AD_WAIT;
            crypto_pkg::ST_AD_WAIT:
                if (!duplex_busy)
                    next_state = range_done ? crypto_pkg::ST_BODY_INIT : crypto_pkg::ST_AD_READ;
            crypto_pkg::ST_AD_READ:
                next_state = crypto_pkg::ST_AD_DATA;
            crypto_pkg::ST_AD_DATA:
                next_state = crypto_pkg::ST_AD_STEP;
            crypto_pkg::ST_AD_STEP:
                next_state = crypto_pkg::ST_AD_WAIT;
            crypto_pkg::ST_BODY_INIT:
                next_state = crypto_pkg::ST_BODY_WAIT;
            crypto_pkg::ST_BODY_WAIT:
                if (!duplex_busy)
                    next_state = range_done ? crypto_pkg::ST_TAG_INIT : crypto_pkg::ST_BODY_READ;
            crypto_pkg::ST_BODY_READ:
                next_state = crypto_pkg::ST_BODY_DATA;
            crypto_pkg::ST_BODY_DATA:
                next_state = crypto_pkg::ST_BODY_STEP;
            crypto_pkg::ST_BODY_STEP:
                next_state = crypto_pkg::ST_BODY_WRITE;
            crypto_pkg::ST_BODY_WRITE:
                next_state = crypto_pkg::ST_BODY_WAIT;
            crypto_pkg::ST_TAG_INIT:
                next_state = crypto_pkg::ST_TAG_WAIT;
            crypto_pkg::ST_TAG_WAIT:
                if (!duplex_busy)
                    next_state = range_done ? crypto_pkg::ST_DONE : crypto_pkg::ST_TAG_STEP;
            crypto_pkg::ST_TAG_STEP:
                next_state = crypto_pkg::ST_TAG_CHECK;
            crypto_pkg::ST_TAG_CHECK:
                if (cmd_unwrap && !tag_match)
                    next_state = crypto_pkg::ST_FAIL;
                else
                    next_state = crypto_pkg::ST_TAG_WAIT;
            default:
                next_state = crypto_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= crypto_pkg::ST_IDLE;
        else
            state <= next_state;
    end

    // word fetched from memory, held for the following duplex step
    always_ff @(posedge clk)
    begin
        if (state == crypto_pkg::ST_AD_DATA || state == crypto_pkg::ST_BODY_DATA)
            din_q <= mem_in;
    end

    assign duplex_in = din_q;
    assign out_base  = r14;

    always_comb
    begin
        busy        = (state != crypto_pkg::ST_IDLE);
        mb_en       = 1'b0;
        mb_wr       = 2'b00;
        reg_write   = 1'b0;
        data_out    = duplex_out;
        ctr_load    = 1'b0;
        ctr_base    = r10;
        ctr_limit   = r11;
        ctr_inc     = 1'b0;
        out_load    = 1'b0;
        out_inc     = 1'b0;
        sel_out     = 1'b0;
        duplex_init = 1'b0;
        duplex_step = 1'b0;
        duplex_op   = crypto_pkg::OP_ABSORB;

        case (state)
            crypto_pkg::ST_AD_INIT:
            begin
                duplex_init = 1'b1;
                ctr_load    = 1'b1;
            end
            crypto_pkg::ST_AD_READ, crypto_pkg::ST_BODY_READ:
            begin
                mb_en   = 1'b1;
                ctr_inc = 1'b1;
            end
            crypto_pkg::ST_AD_STEP:
                duplex_step = 1'b1;
            crypto_pkg::ST_BODY_INIT:
            begin
                ctr_load  = 1'b1;
                ctr_base  = r12;
                ctr_limit = r13;
                out_load  = 1'b1;
            end
            crypto_pkg::ST_BODY_STEP:
            begin
                duplex_step = 1'b1;
                duplex_op   = cmd_unwrap ? crypto_pkg::OP_DECRYPT : crypto_pkg::OP_ENCRYPT;
            end
            crypto_pkg::ST_BODY_WRITE:
            begin
                mb_en   = duplex_ready;
                mb_wr   = 2'b11;
                sel_out = 1'b1;
                out_inc = duplex_ready;
            end
            crypto_pkg::ST_TAG_INIT:
            begin
                ctr_load  = 1'b1;
                ctr_base  = r15;
                ctr_limit = r15 + crypto_pkg::word_t'(crypto_pkg::TAG_BYTES);
            end
            crypto_pkg::ST_TAG_STEP:
            begin
                // unwrap fetches the stored tag word alongside the squeeze
                duplex_step = 1'b1;
                duplex_op   = crypto_pkg::OP_SQUEEZE;
                mb_en       = cmd_unwrap;
            end
            crypto_pkg::ST_TAG_CHECK:
            begin
                mb_en   = cmd_wrap && duplex_ready;
                mb_wr   = cmd_wrap ? 2'b11 : 2'b00;
                ctr_inc = duplex_ready;
            end
            crypto_pkg::ST_FAIL:
            begin
                reg_write = 1'b1;
                data_out  = crypto_pkg::RESULT_FAIL;
            end
            crypto_pkg::ST_DONE:
            begin
                reg_write = 1'b1;
                data_out  = cmd_id      ? sm_data    :
                            cmd_id_prev ? sm_prev_id : crypto_pkg::RESULT_OK;
            end
            default:
            begin
            end
        endcase
    end

endmodule

/* src/crypto_pkg.sv */
package crypto_pkg;

    // security level and derived sizes
    localparam int KEY_BITS    = 64;
    localparam int WORD_BYTES  = 2;
    localparam int TAG_BYTES   = KEY_BITS / 8;

    // duplex permutation
    localparam int PERM_ROUNDS = 4;
    localparam int PERM_ROTATE = 13;

    typedef logic [15:0]         word_t;
    typedef logic [KEY_BITS-1:0] key_t;

    // return values of wrap and unwrap
    localparam word_t RESULT_OK   = 16'h0001;
    localparam word_t RESULT_FAIL = 16'h0000;

    typedef enum logic [1:0] {
        OP_ABSORB,
        OP_ENCRYPT,
        OP_DECRYPT,
        OP_SQUEEZE
    } duplex_op_t;

    typedef enum logic [4:0] {
        ST_IDLE,
        ST_CHECK,
        ST_AD_INIT,
        ST_AD_WAIT,
        ST_AD_READ,
        ST_AD_DATA,
        ST_AD_STEP,
        ST_BODY_INIT,
        ST_BODY_WAIT,
        ST_BODY_READ,
        ST_BODY_DATA,
        ST_BODY_STEP,
        ST_BODY_WRITE,
        ST_TAG_INIT,
        ST_TAG_WAIT,
        ST_TAG_STEP,
        ST_TAG_CHECK,
        ST_FAIL,
        ST_DONE
    } ctrl_state_t;

endpackage

/* src/sponge_duplex.sv */
`timescale 1ns/10ps

module sponge_duplex (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   init,
    input  logic                   step,
    input  crypto_pkg::duplex_op_t op,
    input  crypto_pkg::word_t      data_in,
    input  crypto_pkg::key_t       key,

    output logic                   busy,
    output crypto_pkg::word_t      data_out,
    output logic                   data_out_ready
);

    crypto_pkg::key_t  state;
    crypto_pkg::word_t round;
    crypto_pkg::word_t rate;
    crypto_pkg::word_t new_rate;
    crypto_pkg::word_t out_val;

    // one round rotates, folds the top word into the bottom and mixes in the round number
    function automatic crypto_pkg::key_t permute(crypto_pkg::key_t s, crypto_pkg::word_t k);
        crypto_pkg::key_t  r;
        crypto_pkg::word_t low;
        r   = {s[crypto_pkg::KEY_BITS-1-crypto_pkg::PERM_ROTATE:0],
               s[crypto_pkg::KEY_BITS-1:crypto_pkg::KEY_BITS-crypto_pkg::PERM_ROTATE]};
        low = (r[15:0] + r[crypto_pkg::KEY_BITS-1:crypto_pkg::KEY_BITS-16]) ^ k;
        return {r[crypto_pkg::KEY_BITS-1:16], low};
    endfunction

    assign rate = state[crypto_pkg::KEY_BITS-1:crypto_pkg::KEY_BITS-16];

    always_comb
    begin
        out_val  = rate ^ data_in;
        new_rate = rate;
        case (op)
            crypto_pkg::OP_ABSORB:  new_rate = rate ^ data_in;
            crypto_pkg::OP_ENCRYPT: new_rate = rate ^ data_in;
            crypto_pkg::OP_DECRYPT: new_rate = data_in;
            crypto_pkg::OP_SQUEEZE: out_val  = rate;
            default:                new_rate = rate;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (init)
            state <= key;
        else if (step)
            state <= {new_rate, state[crypto_pkg::KEY_BITS-17:0]};
        else if (busy)
            state <= permute(state, round);
    end

    // rounds run 1..PERM_ROUNDS after each step
    always_ff @(posedge clk)
    begin
        if (reset)
            round <= '0;
        else if (step)
            round <= 16'd1;
        else if (round == crypto_pkg::word_t'(crypto_pkg::PERM_ROUNDS))
            round <= '0;
        else if (busy)
            round <= round + 16'd1;
    end

    assign busy = (round != '0);

    always_ff @(posedge clk)
    begin
        if (reset)
            data_out_ready <= 1'b0;
        else
            data_out_ready <= step && (op != crypto_pkg::OP_ABSORB);
    end

    // held until the next output-producing step
    always_ff @(posedge clk)
    begin
        if (step && op != crypto_pkg::OP_ABSORB)
            data_out <= out_val;
    end

endmodule

/* testbench/crypto_control_asserts.sv */
`timescale 1ns/10ps

module crypto_control_asserts (
    input logic              clk,
    input logic              reset,
    input logic              busy,
    input logic              mb_en,
    input logic              reg_write,
    input crypto_pkg::word_t mab
);

    // memory is only touched inside a command
    mem_in_command: assert property (@(posedge clk) disable iff (reset) mb_en |-> busy)
        else $error("mb_en high while busy is low");

    // result strobe closes the command
    result_then_idle: assert property (@(posedge clk) disable iff (reset)
        reg_write |-> busy ##1 !busy)
        else $error("busy did not fall one cycle after reg_write");

    word_aligned: assert property (@(posedge clk) disable iff (reset) mb_en |-> !mab[0])
        else $error("odd memory address");

    quiet_after_reset: assert property (@(posedge clk) reset |=> !reg_write)
        else $error("reg_write high right after reset");

endmodule

/* testbench/crypto_model.svh */
`ifndef CRYPTO_MODEL_SVH
`define CRYPTO_MODEL_SVH

// reference model of the stand-in duplex whose rate is the top word of the state

// round k rotates left, adds the top word into the bottom word and xors in k
function automatic crypto_pkg::key_t model_round(input crypto_pkg::key_t s, input int k);
    crypto_pkg::key_t r;
    r = (s << crypto_pkg::PERM_ROTATE) | (s >> (64 - crypto_pkg::PERM_ROTATE));
    r[15:0] = (r[15:0] + r[63:48]) ^ 16'(k);
    return r;
endfunction

function automatic crypto_pkg::key_t model_permute(input crypto_pkg::key_t s);
    crypto_pkg::key_t r;
    r = s;
    for (int k = 1; k <= crypto_pkg::PERM_ROUNDS; k++)
        r = model_round(r, k);
    return r;
endfunction

// whole wrap or unwrap over ad_q and body_q, fills out_q and tag_q
task automatic model_run(input crypto_pkg::key_t key, input bit decrypt);
    crypto_pkg::key_t  s;
    crypto_pkg::word_t o;
    s = key;
    out_q.delete();
    tag_q.delete();
    foreach (ad_q[i])
    begin
        s[63:48] = s[63:48] ^ ad_q[i];
        s = model_permute(s);
    end
    foreach (body_q[i])
    begin
        o = s[63:48] ^ body_q[i];
        out_q.push_back(o);
        // decrypt feeds the ciphertext back and encrypt its own output
        s[63:48] = decrypt ? body_q[i] : o;
        s = model_permute(s);
    end
    for (int i = 0; i < crypto_pkg::TAG_BYTES / 2; i++)
    begin
        tag_q.push_back(s[63:48]);
        s = model_permute(s);
    end
endtask

`endif

/* testbench/crypto_control_tb.sv */
`timescale 1ns/10ps

module crypto_control_tb;

    localparam int CLK_PERIOD  = 20;
    localparam int MAX_AD      = 6;
    localparam int MAX_BODY    = 8;
    localparam int TRIPS       = 10;
    localparam int TAG_WORDS   = crypto_pkg::TAG_BYTES / 2;
    // id pairs, invalid lookups, then up to four commands per wrap trip
    localparam int NUM_CMDS    = 16 + 8 + 4 * (TRIPS + 3);
    // per word at most read, load, step, write and the permutation wait
    localparam int CMD_CYCLES  = (MAX_AD + MAX_BODY + TAG_WORDS)
                                 * (crypto_pkg::PERM_ROUNDS + 6) + 20;

    localparam int CMD_WRAP    = 0;
    localparam int CMD_UNWRAP  = 1;
    localparam int CMD_ID      = 2;
    localparam int CMD_ID_PREV = 3;

    logic              clk = 1'b0;
    logic              reset;
    logic              start;
    logic              cmd_wrap;
    logic              cmd_unwrap;
    logic              cmd_id;
    logic              cmd_id_prev;
    crypto_pkg::word_t mem_in;
    crypto_pkg::word_t pc;
    crypto_pkg::word_t r10;
    crypto_pkg::word_t r11;
    crypto_pkg::word_t r12;
    crypto_pkg::word_t r13;
    crypto_pkg::word_t r14;
    crypto_pkg::word_t r15;
    crypto_pkg::word_t sm_data;
    crypto_pkg::key_t  sm_key;
    crypto_pkg::word_t sm_prev_id;
    logic              sm_data_select_valid;
    logic              sm_key_select_valid;
    logic              busy;
    crypto_pkg::word_t sm_data_select;
    crypto_pkg::word_t sm_key_select;
    logic              mb_en;
    logic [1:0]        mb_wr;
    crypto_pkg::word_t mab;
    logic              reg_write;
    crypto_pkg::word_t data_out;

    integer            seed;
    crypto_pkg::word_t mem [crypto_pkg::word_t];
    crypto_pkg::key_t  mod_key [4];
    crypto_pkg::word_t mod_id [4];
    crypto_pkg::word_t ad_q [$];
    crypto_pkg::word_t body_q [$];
    crypto_pkg::word_t out_q [$];
    crypto_pkg::word_t tag_q [$];
    logic              rd_pending = 1'b0;
    crypto_pkg::word_t rd_addr;
    int                writes;

    `include "crypto_model.svh"

    crypto_control i_crypto_control (.*);

    bind crypto_control crypto_control_asserts i_crypto_control_asserts (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // sm table of four 4 KiB modules from 0x8000 and none below
    always_comb
    begin
        sm_key_select_valid  = (sm_key_select[15:14] == 2'b10);
        sm_key               = mod_key[sm_key_select[13:12]];
        sm_data_select_valid = (sm_data_select[15:14] == 2'b10);
        sm_data              = mod_id[sm_data_select[13:12]];
    end

    function automatic crypto_pkg::word_t read_word(input crypto_pkg::word_t a);
        return mem.exists(a) ? mem[a] : ({a[7:0], a[15:8]} ^ 16'hc3a5);
    endfunction

    // read data shows up in the cycle after the request
    always @(negedge clk)
    begin
        if (rd_pending)
            mem_in = read_word(rd_addr);
        rd_pending = mb_en && (mb_wr == 2'b00);
        rd_addr    = mab;
        if (mb_en && mb_wr == 2'b11)
        begin
            mem[mab] = data_out;
            writes   = writes + 1;
        end
    end

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    function automatic crypto_pkg::word_t module_addr(input bit owned);
        crypto_pkg::word_t a;
        a = 16'(rand_below(32768)) << 1;
        a[15:14] = owned ? 2'b10 : 2'b01;
        return a;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
        begin
            $display("Mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic run_cmd(input int which, output crypto_pkg::word_t res);
        @(negedge clk);
        {cmd_wrap, cmd_unwrap, cmd_id, cmd_id_prev} = 4'b1000 >> which;
        writes = 0;
        start  = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check(busy, 1, "busy after start");
        while (!reg_write)
            @(negedge clk);
        res = data_out;
        @(negedge clk);
        check(busy, 0, "busy after reg_write");
    endtask

    // random ranges in separate areas with random data in memory
    task automatic setup_ranges(input int n_ad, input int n_body);
        ad_q.delete();
        body_q.delete();
        pc  = module_addr(1'b1);
        r10 = 16'h1000 + 16'(2 * rand_below(128));
        r11 = r10 + 16'(2 * n_ad);
        r12 = 16'h2000 + 16'(2 * rand_below(128));
        r13 = r12 + 16'(2 * n_body);
        r14 = 16'h3000 + 16'(2 * rand_below(128));
        r15 = 16'h4000 + 16'(2 * rand_below(128));
        for (int i = 0; i < n_ad; i++)
        begin
            ad_q.push_back(16'($random(seed)));
            mem[r10 + 16'(2 * i)] = ad_q[i];
        end
        for (int i = 0; i < n_body; i++)
        begin
            body_q.push_back(16'($random(seed)));
            mem[r12 + 16'(2 * i)] = body_q[i];
        end
    endtask

    task automatic wrap_trip(input int n_ad, input int n_body);
        crypto_pkg::word_t res;
        crypto_pkg::word_t addr;
        crypto_pkg::word_t saved;
        crypto_pkg::word_t plain [$];
        crypto_pkg::key_t  key;

        setup_ranges(n_ad, n_body);
        plain = body_q;
        key   = mod_key[pc[13:12]];
        model_run(key, 1'b0);
        run_cmd(CMD_WRAP, res);
        check(res, crypto_pkg::RESULT_OK, "wrap result");
        check(writes, n_body + TAG_WORDS, "wrap write count");
        foreach (out_q[i])
            check(read_word(r14 + 16'(2 * i)), out_q[i], "ciphertext word");
        foreach (tag_q[i])
            check(read_word(r15 + 16'(2 * i)), tag_q[i], "tag word");

        // decrypt the ciphertext into a fresh buffer
        body_q = out_q;
        model_run(key, 1'b1);
        r12 = r14;
        r13 = r14 + 16'(2 * n_body);
        r14 = 16'h5000 + 16'(2 * rand_below(128));
        run_cmd(CMD_UNWRAP, res);
        check(res, crypto_pkg::RESULT_OK, "unwrap result");
        check(writes, n_body, "unwrap write count");
        foreach (plain[i])
        begin
            check(read_word(r14 + 16'(2 * i)), out_q[i], "decrypted word");
            check(read_word(r14 + 16'(2 * i)), plain[i], "recovered plaintext");
        end

        addr      = r15 + 16'(2 * rand_below(TAG_WORDS));
        saved     = read_word(addr);
        mem[addr] = saved ^ (16'h0001 << rand_below(16));
        run_cmd(CMD_UNWRAP, res);
        check(res, crypto_pkg::RESULT_FAIL, "unwrap with a bad tag");
        check(writes, n_body, "plaintext writes before a bad tag");
        mem[addr] = saved;

        if (n_ad > 0)
        begin
            addr      = r10 + 16'(2 * rand_below(n_ad));
            saved     = read_word(addr);
            mem[addr] = saved ^ (16'h0001 << rand_below(16));
            run_cmd(CMD_UNWRAP, res);
            check(res, crypto_pkg::RESULT_FAIL, "unwrap with bad associated data");
            mem[addr] = saved;
        end
    endtask

    initial
    begin
        #(NUM_CMDS * (CMD_CYCLES + 4) * CLK_PERIOD + 10 * CLK_PERIOD);
        $display("Watchdog expired: the commands did not finish in time");
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    end

    initial
    begin
        crypto_pkg::word_t res;

        seed        = 32'h8028_03eb;
        reset       = 1'b1;
        start       = 1'b0;
        cmd_wrap    = 1'b0;
        cmd_unwrap  = 1'b0;
        cmd_id      = 1'b0;
        cmd_id_prev = 1'b0;
        mem_in      = '0;
        pc          = '0;
        r10         = '0;
        r11         = '0;
        r12         = '0;
        r13         = '0;
        r14         = '0;
        r15         = '0;
        sm_prev_id  = '0;
        writes      = 0;
        for (int i = 0; i < 4; i++)
        begin
            mod_key[i] = {$random(seed), $random(seed)};
            mod_id[i]  = 16'($random(seed));
        end
        repeat (2) @(negedge clk);
        reset = 1'b0;

        // lookups of a valid module while the other select is invalid
        repeat (8)
        begin
            pc         = module_addr(1'b0);
            r15        = module_addr(1'b1);
            sm_prev_id = 16'($random(seed));
            run_cmd(CMD_ID, res);
            check(res, mod_id[r15[13:12]], "id result");
            check(writes, 0, "id write count");
            pc  = module_addr(1'b1);
            r15 = module_addr(1'b0);
            run_cmd(CMD_ID_PREV, res);
            check(res, sm_prev_id, "id_prev result");
        end

        // id needs the data select and the others the key select
        for (int c = 0; c < 4; c++)
        begin
            repeat (2)
            begin
                setup_ranges(rand_below(MAX_AD + 1), rand_below(MAX_BODY + 1));
                pc  = module_addr(c == CMD_ID);
                r15 = module_addr(c != CMD_ID);
                run_cmd(c, res);
                check(res, crypto_pkg::RESULT_FAIL, "result for an invalid module");
                check(writes, 0, "writes for an invalid module");
            end
        end

        repeat (TRIPS)
            wrap_trip(rand_below(MAX_AD + 1), rand_below(MAX_BODY + 1));

        // empty ranges
        wrap_trip(0, rand_below(MAX_BODY) + 1);
        wrap_trip(rand_below(MAX_AD) + 1, 0);
        wrap_trip(0, 0);

        $display("Simulation PASSED");
        $finish;
    end

endmodule
